//--- rtl/terminalPkg.sv
package terminalPkg;

    //////////////////////////////
    // character and frame types
    //////////////////////////////

    // one byte of serial text or one raw scan code
    typedef logic [7:0] charT;

    // decoded ps/2 frame
    // parityOk set when data plus parity bit xor to one
    typedef struct packed {
        charT code;
        logic parityOk;
    } ps2FrameT;

    //////////////////////////////
    // keyboard protocol codes
    //////////////////////////////

    // break prefix, sent ahead of the code of a released key
    localparam charT breakPrefix = 8'hF0;
    // keyboard resend request, never echoed
    localparam charT resendCode = 8'hFE;

    //////////////////////////////
    // greeting banner
    //////////////////////////////

    // 21 printable characters plus cr and lf
    localparam int bannerLen = 23;

    // first character sits in the top byte
    localparam logic [bannerLen*8-1:0] bannerText = {
        "Hello, terminal ready",
        8'h0D,
        8'h0A
    };

endpackage

//--- rtl/ps2Receiver.sv
`timescale 1ns/1ps

module ps2Receiver (
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 ps2Clk,
    input  logic                 ps2Data,
    output terminalPkg::ps2FrameT frame,
    output logic                 frameValid
);

    //////////////////////////////
    // synchronizers
    //////////////////////////////

    // two flops into the clock domain, third flop for edge detect
    logic [2:0] clkSync;
    logic [1:0] dataSync;
    logic       clkFall;
    logic       dataBit;

    // frame assembly
    logic [3:0] bitCount;
    logic [8:0] shiftReg;
    logic       lastBit;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            // both lines idle high on the bus
            clkSync  <= '1;
            dataSync <= '1;
        end else begin
            clkSync  <= {clkSync[1:0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
        end
    end

    // keyboard drives data on the rising edge, so sample on the fall
    assign clkFall = clkSync[2] & ~clkSync[1];
    assign dataBit = dataSync[1];
    // bit 10 is the stop bit
    assign lastBit = (bitCount == 4'd10);

    //////////////////////////////
    // bit counter
    //////////////////////////////

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            bitCount   <= '0;
            frameValid <= 1'b0;
        end else begin
            frameValid <= 1'b0;
            if (clkFall) begin
                if (bitCount == 4'd0) begin
                    // wait for a low start bit, stay put otherwise
                    if (!dataBit) begin
                        bitCount <= 4'd1;
                    end
                end else if (lastBit) begin
                    bitCount <= '0;
                    // stop bit must be high, else the frame is thrown away
                    frameValid <= dataBit;
                end else begin
                    bitCount <= bitCount + 4'd1;
                end
            end
        end
    end

    // data lsb first then parity, shifted in from the top
    always_ff @(posedge CLK) begin
        if (clkFall && (bitCount != 4'd0) && !lastBit) begin
            shiftReg <= {dataBit, shiftReg[8:1]};
        end
    end

    // present the code together with its odd-parity result
    always_ff @(posedge CLK) begin
        if (clkFall && lastBit) begin
            frame.code     <= shiftReg[7:0];
            frame.parityOk <= ^shiftReg;
        end
    end

    // valid is a strobe, never a level
    frameValidPulse: assert property (
        @(posedge CLK) disable iff (!rstN)
        frameValid |=> !frameValid
    ) else $error("frameValid held longer than one cycle");

endmodule

//--- rtl/consoleSequencer.sv
`timescale 1ns/1ps

module consoleSequencer (
    input  logic                  CLK,
    input  logic                  rstN,
    input  terminalPkg::ps2FrameT frame,
    input  logic                  frameValid,
    input  logic                  full,
    output logic                  push,
    output terminalPkg::charT     pushData
);

    // index must be able to hold bannerLen itself
    localparam int idxW = $clog2(terminalPkg::bannerLen + 1);

    logic [idxW-1:0]   bannerIdx;
    logic              bannerDone;
    terminalPkg::charT bannerChar;

    // echo path
    logic              frameOk;
    logic              breakArmed;
    logic              echoPending;
    terminalPkg::charT echoData;

    //////////////////////////////
    // banner phase
    //////////////////////////////

    // echo state once every banner byte is queued
    assign bannerDone = (bannerIdx == idxW'(terminalPkg::bannerLen));

    // byte select, first char in the top byte
    assign bannerChar =
        terminalPkg::bannerText[8*(terminalPkg::bannerLen - 1 - int'(bannerIdx)) +: 8];

    // bad parity frames never reach the echo logic
    assign frameOk = frameValid && frame.parityOk;

    //////////////////////////////
    // push mux
    //////////////////////////////

    // banner pushes every cycle the fifo has room
    // a pending echo that meets full is simply lost
    assign push     = bannerDone ? (echoPending && !full) : !full;
    assign pushData = bannerDone ? echoData : bannerChar;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            bannerIdx   <= '0;
            breakArmed  <= 1'b0;
            echoPending <= 1'b0;
        end else begin
            echoPending <= 1'b0;
            // stall on the same char while full
            if (!bannerDone && !full) begin
                bannerIdx <= bannerIdx + 1'b1;
            end
            // frames before banner completion are dropped
            if (bannerDone && frameOk) begin
                if (breakArmed) begin
                    // code after F0 is the released key
                    breakArmed  <= 1'b0;
                    echoPending <= (frame.code != terminalPkg::resendCode);
                end else if (frame.code == terminalPkg::breakPrefix) begin
                    breakArmed <= 1'b1;
                end
                // make codes alone fall through here
            end
        end
    end

    // released code held for the push one cycle later
    always_ff @(posedge CLK) begin
        if (bannerDone && frameOk && breakArmed) begin
            echoData <= frame.code;
        end
    end

    // released key reaches the fifo one cycle after its frame
    echoNextCycle: assert property (
        @(posedge CLK) disable iff (!rstN)
        bannerDone && frameOk && breakArmed && (frame.code != terminalPkg::resendCode)
            |=> push || full
    ) else $error("released key not pushed one cycle after its frame");

endmodule

//--- rtl/charFifo.sv
`timescale 1ns/1ps

module charFifo #(
    parameter int fifoDepth = 8
) (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              push,
    input  terminalPkg::charT pushData,
    input  logic              pop,
    output terminalPkg::charT popData,
    output logic              full,
    output logic              empty
);

    localparam int addrW = $clog2(fifoDepth);

    // storage
    terminalPkg::charT mem [fifoDepth];

    // extra msb tells a wrapped writer from an equal reader
    logic [addrW:0] wrPtr;
    logic [addrW:0] rdPtr;
    logic           doWrite;
    logic           doRead;

    //////////////////////////////
    // status flags
    //////////////////////////////

    assign empty = (wrPtr == rdPtr);
    // same slot, different lap
    assign full = (wrPtr[addrW] != rdPtr[addrW]) &&
                  (wrPtr[addrW-1:0] == rdPtr[addrW-1:0]);

    // overflow and underflow requests are ignored
    assign doWrite = push && !full;
    assign doRead  = pop && !empty;

    // fall-through read, head of queue always on popData
    assign popData = mem[rdPtr[addrW-1:0]];

    always_ff @(posedge CLK) begin
        if (doWrite) begin
            mem[wrPtr[addrW-1:0]] <= pushData;
        end
    end

    //////////////////////////////
    // pointers
    //////////////////////////////

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    // sequencer must check full before it pushes
    noPushWhenFull: assert property (
        @(posedge CLK) disable iff (!rstN)
        push |-> !full
    ) else $error("push while character buffer full");

    // transmitter must check empty before it pops
    noPopWhenEmpty: assert property (
        @(posedge CLK) disable iff (!rstN)
        pop |-> !empty
    ) else $error("pop while character buffer empty");

endmodule

//--- rtl/uartTx.sv
`timescale 1ns/1ps

module uartTx #(
    parameter int clksPerBit = 8
) (
    input  logic              CLK,
    input  logic              rstN,
    input  logic              empty,
    input  terminalPkg::charT popData,
    output logic              pop,
    output logic              txd
);

    localparam int cntW = (clksPerBit > 1) ? $clog2(clksPerBit) : 1;

    typedef enum logic [1:0] {
        stIdle,
        stStart,
        stData,
        stStop
    } txStateT;

    txStateT           state;
    logic [cntW-1:0]   baudCnt;
    logic [2:0]        bitIdx;
    logic              bitEnd;
    terminalPkg::charT txByte;

    // last cycle of the current bit period
    assign bitEnd = (baudCnt == cntW'(clksPerBit - 1));

    // take a char only from idle
    assign pop = (state == stIdle) && !empty;

    //////////////////////////////
    // frame FSM
    //////////////////////////////

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state   <= stIdle;
            baudCnt <= '0;
            bitIdx  <= '0;
            txd     <= 1'b1;
        end else begin
            baudCnt <= bitEnd ? '0 : baudCnt + 1'b1;
            case (state)
                stIdle: begin
                    baudCnt <= '0;
                    if (pop) begin
                        // start bit goes out next cycle
                        state <= stStart;
                        txd   <= 1'b0;
                    end
                end
                stStart: begin
                    if (bitEnd) begin
                        state  <= stData;
                        bitIdx <= '0;
                        txd    <= txByte[0];
                    end
                end
                stData: begin
                    if (bitEnd) begin
                        if (bitIdx == 3'd7) begin
                            state <= stStop;
                            txd   <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 3'd1;
                            txd    <= txByte[1];
                        end
                    end
                end
                stStop: begin
                    // line already high, just hold for one bit
                    if (bitEnd) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // lsb first, shift right after each data bit
    always_ff @(posedge CLK) begin
        if (pop) begin
            txByte <= popData;
        end else if (state == stData && bitEnd) begin
            txByte <= txByte >> 1;
        end
    end

    // line rests high between frames
    idleLineHigh: assert property (
        @(posedge CLK) disable iff (!rstN)
        (state == stIdle) |-> txd
    ) else $error("txd low while transmitter idle");

endmodule

//--- rtl/terminalTop.sv
`timescale 1ns/1ps

module terminalTop #(
    parameter int clksPerBit = 8,
    parameter int fifoDepth  = 8
) (
    input  logic CLK,
    input  logic rstN,
    input  logic ps2Clk,
    input  logic ps2Data,
    output logic txd
);

    //////////////////////////////
    // interconnect
    //////////////////////////////

    // keyboard side
    terminalPkg::ps2FrameT frame;
    logic                  frameValid;

    // sequencer into the buffer
    logic                  push;
    terminalPkg::charT     pushData;
    logic                  full;

    // buffer into the transmitter
    logic                  pop;
    terminalPkg::charT     popData;
    logic                  empty;

    // frame decode
    ps2Receiver uPs2Receiver (
        .CLK        (CLK),
        .rstN       (rstN),
        .ps2Clk     (ps2Clk),
        .ps2Data    (ps2Data),
        .frame      (frame),
        .frameValid (frameValid)
    );

    // banner then key echo
    consoleSequencer uConsoleSequencer (
        .CLK        (CLK),
        .rstN       (rstN),
        .frame      (frame),
        .frameValid (frameValid),
        .full       (full),
        .push       (push),
        .pushData   (pushData)
    );

    // rate decoupling between keyboard and serial line
    charFifo #(
        .fifoDepth (fifoDepth)
    ) uCharFifo (
        .CLK      (CLK),
        .rstN     (rstN),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .popData  (popData),
        .full     (full),
        .empty    (empty)
    );

    // 8N1 output
    uartTx #(
        .clksPerBit (clksPerBit)
    ) uUartTx (
        .CLK     (CLK),
        .rstN    (rstN),
        .empty   (empty),
        .popData (popData),
        .pop     (pop),
        .txd     (txd)
    );

endmodule

//--- tb/terminalDriver.svh
`ifndef TERMINAL_DRIVER_SVH
`define TERMINAL_DRIVER_SVH

// advance n clock cycles, land a little after the rising edge
task automatic waitCycles(input int n);
    repeat (n) @(posedge CLK);
    #2;
endtask

//////////////////////////////
// ps/2 keyboard side
//////////////////////////////

// start, 8 data lsb first, odd parity, stop
// data changes while the ps/2 clock is high
task automatic sendFrame(input terminalPkg::charT code, input bit badParity);
    logic [10:0] bits;
    logic        parity;
    parity = ~^code;
    if (badParity) begin
        parity = ~parity;
    end
    bits = {1'b1, parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
        ps2Data = bits[i];
        waitCycles(ps2Half);
        // receiver samples on this fall
        ps2Clk = 1'b0;
        waitCycles(ps2Half);
        ps2Clk = 1'b1;
    end
    ps2Data = 1'b1;
    waitCycles(frameGap);
endtask

//////////////////////////////
// uart side
//////////////////////////////

// poll for the start bit, then sample every bit at its middle
task automatic recvByte(output terminalPkg::charT data, output bit ok, input int timeoutCycles);
    int waited;
    ok     = 1'b0;
    data   = '0;
    waited = 0;
    while (txd && waited < timeoutCycles) begin
        waitCycles(1);
        waited++;
    end
    if (txd) begin
        $display("no start bit on txd within %0d cycles", timeoutCycles);
        errCount++;
    end else begin
        // half a bit on from the falling edge
        waitCycles(clksPerBit / 2);
        if (txd) begin
            $display("start bit on txd did not stay low");
            errCount++;
        end
        for (int i = 0; i < 8; i++) begin
            waitCycles(clksPerBit);
            data[i] = txd;
        end
        waitCycles(clksPerBit);
        if (!txd) begin
            $display("stop bit missing on txd after byte %h", data);
            errCount++;
        end else begin
            ok = 1'b1;
        end
    end
endtask

//////////////////////////////
// compare tasks
//////////////////////////////

task automatic checkChar(input string name, input terminalPkg::charT got,
                         input terminalPkg::charT exp);
    if (got !== exp) begin
        $display("FAIL %s got %h exp %h", name, got, exp);
        errCount++;
    end
endtask

task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %s got %h exp %h", name, got, exp);
        errCount++;
    end
endtask

// any start bit inside the window is an unexpected byte
task automatic checkSilent(input string what, input int cycles);
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < cycles; i++) begin
        waitCycles(1);
        if (!txd && !seen) begin
            seen = 1'b1;
            $display("unexpected byte on txd after %s", what);
            errCount++;
        end
    end
endtask

`endif

//--- tb/tbTerminal.sv
`timescale 1ns/1ps

module tbTerminal;

    localparam int clksPerBit = 8;
    localparam int fifoDepth  = 8;
    // 400 ns ps/2 half period in 20 ns cycles
    localparam int ps2Half      = 20;
    localparam int frameGap     = 20;
    localparam int frameCycles  = 22 * ps2Half + frameGap;
    // two uart frames plus slack
    localparam int windowCycles = 2 * 10 * clksPerBit + 20;
    localparam int recvTimeout  = 3 * frameCycles;
    // banner plus 20 bytes, 30 ps/2 frames, then half again
    localparam int watchdogNs =
        ((terminalPkg::bannerLen + 20) * 10 * clksPerBit * 20 + 30 * 11 * 800) * 3 / 2;

    logic        CLK;
    logic        rstN;
    logic        ps2Clk;
    logic        ps2Data;
    logic        txd;
    int          errCount;
    int          passCount;
    int          failCount;

    `include "terminalDriver.svh"

    terminalTop #(
        .clksPerBit (clksPerBit),
        .fifoDepth  (fifoDepth)
    ) dut (
        .CLK     (CLK),
        .rstN    (rstN),
        .ps2Clk  (ps2Clk),
        .ps2Data (ps2Data),
        .txd     (txd)
    );

    // 20 ns period
    always #10 CLK = ~CLK;

    // any key below the break prefix
    function automatic terminalPkg::charT randomCode();
        return terminalPkg::charT'($urandom % 240);
    endfunction

    task automatic reportTest(input string name, input int errsBefore);
        if (errCount == errsBefore) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errCount - errsBefore);
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic resetAndBanner();
        int                errsBefore;
        string             bannerExp;
        terminalPkg::charT got;
        bit                ok;
        errsBefore = errCount;
        bannerExp  = "Hello, terminal ready\r\n";
        if (bannerExp.len() != terminalPkg::bannerLen) begin
            $display("banner length %0d does not match expected text", terminalPkg::bannerLen);
            errCount++;
        end
        rstN = 1'b0;
        for (int i = 0; i < 5; i++) begin
            waitCycles(1);
            checkLevel("txd in reset", txd, 1'b1);
        end
        rstN = 1'b1;
        // first cycle out of reset, start bit not yet on the line
        waitCycles(1);
        checkLevel("txd after reset", txd, 1'b1);
        for (int i = 0; i < bannerExp.len(); i++) begin
            recvByte(got, ok, recvTimeout);
            if (ok) begin
                checkChar($sformatf("banner[%0d]", i), got, bannerExp[i]);
            end
        end
        // nothing beyond the last line feed
        checkSilent("banner", windowCycles);
        reportTest("reset and banner", errsBefore);
    endtask

    task automatic releaseEcho();
        int                errsBefore;
        terminalPkg::charT code;
        terminalPkg::charT got;
        bit                ok;
        errsBefore = errCount;
        code       = randomCode();
        // make code alone stays silent
        fork
            sendFrame(code, 1'b0);
            checkSilent("make code", frameCycles + windowCycles);
        join
        fork
            begin
                sendFrame(terminalPkg::breakPrefix, 1'b0);
                sendFrame(code, 1'b0);
            end
            begin
                recvByte(got, ok, recvTimeout);
                if (ok) begin
                    checkChar("echo", got, code);
                end
            end
        join
        checkSilent("release echo", windowCycles);
        reportTest("release echo", errsBefore);
    endtask

    task automatic resendSuppress();
        int errsBefore;
        errsBefore = errCount;
        fork
            begin
                sendFrame(terminalPkg::breakPrefix, 1'b0);
                sendFrame(terminalPkg::resendCode, 1'b0);
            end
            checkSilent("resend code", 2 * frameCycles + windowCycles);
        join
        reportTest("resend suppression", errsBefore);
    endtask

    task automatic parityReject();
        int                errsBefore;
        terminalPkg::charT code;
        terminalPkg::charT code2;
        terminalPkg::charT got;
        bit                ok;
        errsBefore = errCount;
        code       = randomCode();
        code2      = randomCode();
        while (code2 == code) begin
            code2 = randomCode();
        end
        // broken F0, so the next code is only a make code
        fork
            begin
                sendFrame(terminalPkg::breakPrefix, 1'b1);
                sendFrame(code, 1'b0);
            end
            checkSilent("corrupt break prefix", 2 * frameCycles + windowCycles);
        join
        fork
            begin
                sendFrame(terminalPkg::breakPrefix, 1'b0);
                sendFrame(code2, 1'b0);
            end
            begin
                recvByte(got, ok, recvTimeout);
                if (ok) begin
                    checkChar("echo after parity error", got, code2);
                end
            end
        join
        checkSilent("echo after parity error", windowCycles);
        reportTest("parity rejection", errsBefore);
    endtask

    task automatic bufferedReleases();
        int                errsBefore;
        terminalPkg::charT codes [4];
        terminalPkg::charT got;
        bit                ok;
        errsBefore = errCount;
        for (int i = 0; i < 4; i++) begin
            codes[i] = randomCode();
        end
        fork
            for (int i = 0; i < 4; i++) begin
                sendFrame(terminalPkg::breakPrefix, 1'b0);
                sendFrame(codes[i], 1'b0);
            end
            for (int j = 0; j < 4; j++) begin
                recvByte(got, ok, recvTimeout);
                if (ok) begin
                    checkChar($sformatf("buffered[%0d]", j), got, codes[j]);
                end
            end
        join
        checkSilent("buffered releases", windowCycles);
        reportTest("buffering", errsBefore);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        CLK       = 1'b0;
        rstN      = 1'b0;
        ps2Clk    = 1'b1;
        ps2Data   = 1'b1;
        errCount  = 0;
        passCount = 0;
        failCount = 0;
        void'($urandom(32'hf8ba));
        resetAndBanner();
        releaseEcho();
        resendSuppress();
        parityReject();
        bufferedReleases();
        $display("summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // hard stop in case a test hangs
    initial begin
        #(watchdogNs);
        $display("timeout after %0d ns, tests did not finish", watchdogNs);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- terminal.f
+incdir+tb
rtl/terminalPkg.sv
rtl/ps2Receiver.sv
rtl/consoleSequencer.sv
rtl/charFifo.sv
rtl/uartTx.sv
rtl/terminalTop.sv
tb/tbTerminal.sv

//--- run.sh
#!/usr/bin/env bash
# build the terminal testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbTerminal \
    -f terminal.f \
    && ./obj_dir/VtbTerminal | tee /dev/stderr | grep -q "^Verification passed$" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
